// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sldu -f sldu_top.f -o tb_sldu_sim \
  && ./obj_dir/tb_sldu_sim | tee sim.log

# The log decides, a missing log counts as a failure
grep -qsx "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

// File: sldu_insn_queue.sv
`timescale 1ns/1ps

module sldu_insn_queue #(
  parameter int unsigned NrLanes        = 2,
  parameter int unsigned InsnQueueDepth = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_valid_i,
  input  sldu_pkg::slide_op_e          req_op_i,
  input  sldu_pkg::vsew_e              req_vsew_i,
  input  sldu_pkg::vlen_t              req_vl_i,
  input  sldu_pkg::vlen_t              req_stride_i,
  input  sldu_pkg::vreg_t              req_vd_i,
  input  sldu_pkg::vid_t               req_id_i,
  input  logic                         issue_done_i,
  input  logic                         row_retired_i,
  output logic                         req_ready_o,
  output logic                         issue_valid_o,
  output sldu_pkg::slide_op_e          issue_op_o,
  output sldu_pkg::vsew_e              issue_vsew_o,
  output sldu_pkg::vlen_t              issue_bytes_o,
  output sldu_pkg::vlen_t              issue_offset_o,
  output sldu_pkg::vreg_t              issue_vd_o,
  output sldu_pkg::vid_t               issue_id_o,
  output logic [sldu_pkg::NrVInsn-1:0] done_o
);
  import sldu_pkg::*;

  localparam int unsigned RowBytes = NrLanes * LaneBytes;
  localparam int unsigned RowIdxW  = $clog2(RowBytes);
  localparam int unsigned PntW     = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW     = $clog2(InsnQueueDepth + 1);

  // Stored instructions, lengths already in bytes
  slide_op_e op_q     [InsnQueueDepth];
  vsew_e     vsew_q   [InsnQueueDepth];
  vlen_t     bytes_q  [InsnQueueDepth];
  vlen_t     offset_q [InsnQueueDepth];
  vlen_t     rows_q   [InsnQueueDepth];
  vreg_t     vd_q     [InsnQueueDepth];
  vid_t      id_q     [InsnQueueDepth];

  // One pointer per phase, plus instructions left to issue and to commit
  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [CntW-1:0] issue_cnt_q, commit_cnt_q;

  // Rows already retired for the instruction at the commit pointer
  vlen_t rows_done_q, rows_done_d;

  logic        accept;
  logic        commit_valid;
  logic        done;
  logic [16:0] vl_b, off_b, bytes_b, out0_b, rows_b;

  assign req_ready_o = (commit_cnt_q != CntW'(InsnQueueDepth));
  assign accept      = req_valid_i && req_ready_o;

  ////////////////////////////////////////////////////////////////////
  // Byte counts at acceptance
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    // Elements to bytes
    vl_b  = 17'(req_vl_i) << req_vsew_i;
    off_b = 17'(req_stride_i) << req_vsew_i;
    if (req_op_i == OP_SLIDEUP) begin
      // Bytes below the offset stay untouched
      bytes_b = (off_b < vl_b) ? vl_b - off_b : '0;
      out0_b  = 17'(off_b[RowIdxW-1:0]);
    end else begin
      bytes_b = vl_b;
      out0_b  = '0;
    end
    // Destination rows touched, counted from the first written byte
    if (bytes_b == '0) begin
      rows_b = '0;
    end else begin
      rows_b = (out0_b + bytes_b + 17'(RowBytes - 1)) >> RowIdxW;
    end
  end

  // Issue slot straight from storage, valid one cycle after acceptance
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign issue_op_o     = op_q[issue_pnt_q];
  assign issue_vsew_o   = vsew_q[issue_pnt_q];
  assign issue_bytes_o  = bytes_q[issue_pnt_q];
  assign issue_offset_o = offset_q[issue_pnt_q];
  assign issue_vd_o     = vd_q[issue_pnt_q];
  assign issue_id_o     = id_q[issue_pnt_q];

  ////////////////////////////////////////////////////////////////////
  // Commit tracking
  ////////////////////////////////////////////////////////////////////

  // Commit head has left the issue phase
  assign commit_valid = (commit_cnt_q != issue_cnt_q);
  assign rows_done_d  = rows_done_q + vlen_t'(row_retired_i);
  // Zero-row instructions finish as soon as they are issued
  assign done         = commit_valid && (rows_done_d == rows_q[commit_pnt_q]);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]     <= req_op_i;
      vsew_q[accept_pnt_q]   <= req_vsew_i;
      bytes_q[accept_pnt_q]  <= bytes_b[15:0];
      offset_q[accept_pnt_q] <= off_b[15:0];
      rows_q[accept_pnt_q]   <= rows_b[15:0];
      vd_q[accept_pnt_q]     <= req_vd_i;
      id_q[accept_pnt_q]     <= req_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      rows_done_q  <= '0;
      done_o       <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= (accept_pnt_q == PntW'(InsnQueueDepth - 1)) ? '0 : accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= (issue_pnt_q == PntW'(InsnQueueDepth - 1)) ? '0 : issue_pnt_q + 1'b1;
      end
      if (done) begin
        commit_pnt_q <= (commit_pnt_q == PntW'(InsnQueueDepth - 1)) ? '0 : commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(done);
      rows_done_q  <= done ? '0 : rows_done_d;
      // One-hot pulse on the finished id
      done_o <= '0;
      if (done) begin
        done_o[id_q[commit_pnt_q]] <= 1'b1;
      end
    end
  end

endmodule

// File: sldu_pkg.sv
package sldu_pkg;

  ////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////

  // One lane word and its byte count
  localparam int unsigned ElenBits  = 64;
  localparam int unsigned LaneBytes = ElenBits / 8;

  // Instruction ids, one done bit per id
  localparam int unsigned VidBits = 3;
  localparam int unsigned NrVInsn = 2 ** VidBits;

  // Rows of the register file taken by one vector register
  localparam int unsigned RowsPerVreg = 16;

  typedef logic [VidBits-1:0] vid_t;
  typedef logic [15:0]        vlen_t;
  typedef logic [15:0]        vaddr_t;
  typedef logic [4:0]         vreg_t;

  ////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////

  typedef enum logic {
    OP_SLIDEUP,
    OP_SLIDEDOWN
  } slide_op_e;

  // Element width, also the shift from elements to bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vsew_e;

  // Lane word, packed as bytes by the engine and read whole by the lanes
  typedef union packed {
    logic [ElenBits-1:0]            word;
    logic [LaneBytes-1:0][7:0]      bytes;
  } lane_word_u;

endpackage

// File: sldu_result_queue.sv
`timescale 1ns/1ps

module sldu_result_queue #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        push_i,
  input  sldu_pkg::lane_word_u [NrLanes-1:0]          push_wdata_i,
  input  logic [NrLanes-1:0][sldu_pkg::LaneBytes-1:0] push_be_i,
  input  sldu_pkg::vaddr_t                            push_addr_i,
  input  sldu_pkg::vid_t                              push_id_i,
  input  logic [NrLanes-1:0]                          result_gnt_i,
  output logic                                        full_o,
  output logic                                        row_retired_o,
  output logic [NrLanes-1:0]                          result_req_o,
  output sldu_pkg::vaddr_t [NrLanes-1:0]              result_addr_o,
  output sldu_pkg::vid_t [NrLanes-1:0]                result_id_o,
  output sldu_pkg::lane_word_u [NrLanes-1:0]          result_wdata_o,
  output logic [NrLanes-1:0][sldu_pkg::LaneBytes-1:0] result_be_o
);
  import sldu_pkg::*;

  localparam int unsigned PntW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;

  // Row slots
  lane_word_u [ResultQueueDepth-1:0][NrLanes-1:0]                wdata_q;
  logic       [ResultQueueDepth-1:0][NrLanes-1:0][LaneBytes-1:0] be_q;
  vaddr_t     [ResultQueueDepth-1:0]                             addr_q;
  vid_t       [ResultQueueDepth-1:0]                             id_q;

  // Lanes of each slot still waiting for a grant
  logic [ResultQueueDepth-1:0][NrLanes-1:0] valid_q, valid_d;

  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntW:0]   cnt_q;

  assign full_o        = (cnt_q == (PntW + 1)'(ResultQueueDepth));
  // Head slot is done once every lane has been granted
  assign row_retired_o = (cnt_q != '0) && !(|valid_q[rd_pnt_q]);

  // Every lane sees the head slot
  always_comb begin
    for (int l = 0; l < int'(NrLanes); l++) begin
      result_req_o[l]   = valid_q[rd_pnt_q][l];
      result_addr_o[l]  = addr_q[rd_pnt_q];
      result_id_o[l]    = id_q[rd_pnt_q];
      result_wdata_o[l] = wdata_q[rd_pnt_q][l];
      result_be_o[l]    = be_q[rd_pnt_q][l];
    end
  end

  always_comb begin
    valid_d = valid_q;
    // A grant drops that lane's request next cycle
    for (int l = 0; l < int'(NrLanes); l++) begin
      if (valid_q[rd_pnt_q][l] && result_gnt_i[l]) begin
        valid_d[rd_pnt_q][l] = 1'b0;
      end
    end
    // All lanes request, even those with no enabled byte
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      id_q[wr_pnt_q]    <= push_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (push_i) begin
        wr_pnt_q <= (wr_pnt_q == PntW'(ResultQueueDepth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (row_retired_o) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(ResultQueueDepth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (PntW + 1)'(push_i) - (PntW + 1)'(row_retired_o);
    end
  end

endmodule

// File: sldu_slide_engine.sv
`timescale 1ns/1ps

module sldu_slide_engine #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        issue_valid_i,
  input  sldu_pkg::slide_op_e                         issue_op_i,
  input  sldu_pkg::vsew_e                             issue_vsew_i,
  input  sldu_pkg::vlen_t                             issue_bytes_i,
  input  sldu_pkg::vlen_t                             issue_offset_i,
  input  sldu_pkg::vreg_t                             issue_vd_i,
  input  sldu_pkg::vid_t                              issue_id_i,
  input  sldu_pkg::lane_word_u [NrLanes-1:0]          operand_i,
  input  logic [NrLanes-1:0]                          operand_valid_i,
  input  logic                                        rq_full_i,
  output logic [NrLanes-1:0]                          operand_ready_o,
  output logic                                        issue_done_o,
  output logic                                        push_o,
  output sldu_pkg::lane_word_u [NrLanes-1:0]          push_wdata_o,
  output logic [NrLanes-1:0][sldu_pkg::LaneBytes-1:0] push_be_o,
  output sldu_pkg::vaddr_t                            push_addr_o,
  output sldu_pkg::vid_t                              push_id_o
);
  import sldu_pkg::*;

  localparam int unsigned RowBytes = NrLanes * LaneBytes;
  localparam int unsigned RowIdxW  = $clog2(RowBytes);
  localparam int unsigned PntW     = RowIdxW + 1;

  // FSM encoding
  localparam logic StIdle = 1'b0;
  localparam logic StRun  = 1'b1;

  logic state_q, state_d;

  // Byte pointers inside the source and destination rows
  logic [PntW-1:0] in_pnt_q, in_pnt_d;
  logic [PntW-1:0] out_pnt_q, out_pnt_d;
  // Bytes still to copy
  vlen_t cnt_q, cnt_d;
  // Row index inside the destination register
  vaddr_t vrf_pnt_q, vrf_pnt_d;

  // Partial result row
  lane_word_u [NrLanes-1:0]                row_q, row_d;
  logic       [NrLanes-1:0][LaneBytes-1:0] be_q, be_d;

  logic [PntW-1:0] in_left, out_left, step;
  logic            last;
  int              src_b;
  int              dst_b;

  assign push_wdata_o = row_d;
  assign push_be_o    = be_d;
  assign push_addr_o  = vaddr_t'(issue_vd_i) * vaddr_t'(RowsPerVreg) + vrf_pnt_q;
  assign push_id_o    = issue_id_i;

  always_comb begin
    state_d   = state_q;
    in_pnt_d  = in_pnt_q;
    out_pnt_d = out_pnt_q;
    cnt_d     = cnt_q;
    vrf_pnt_d = vrf_pnt_q;
    row_d     = row_q;
    be_d      = be_q;

    operand_ready_o = '0;
    issue_done_o    = 1'b0;
    push_o          = 1'b0;

    // Room left in whichever row ends first
    in_left  = PntW'(RowBytes) - in_pnt_q;
    out_left = PntW'(RowBytes) - out_pnt_q;
    step     = (in_left < out_left) ? in_left : out_left;
    if (cnt_q < vlen_t'(step)) begin
      step = cnt_q[PntW-1:0];
    end
    // Steps move whole elements only
    step = (step >> issue_vsew_i) << issue_vsew_i;
    last = (cnt_q <= vlen_t'(step));

    unique case (state_q)
      ////////////////////////////////////////////////////////////////
      // Load pointers from the issue slot
      ////////////////////////////////////////////////////////////////
      StIdle: begin
        if (issue_valid_i) begin
          if (issue_bytes_i == '0) begin
            // Nothing to write, release the slot at once
            issue_done_o = 1'b1;
          end else begin
            state_d = StRun;
            cnt_d   = issue_bytes_i;
            if (issue_op_i == OP_SLIDEUP) begin
              // Read from the start, write from the offset
              in_pnt_d  = '0;
              out_pnt_d = PntW'(issue_offset_i[RowIdxW-1:0]);
              vrf_pnt_d = issue_offset_i >> RowIdxW;
            end else begin
              // Lanes start at the offset row, so only the byte part matters
              in_pnt_d  = PntW'(issue_offset_i[RowIdxW-1:0]);
              out_pnt_d = '0;
              vrf_pnt_d = '0;
            end
          end
        end
      end

      ////////////////////////////////////////////////////////////////
      // Copy bytes, one source row at most per cycle
      ////////////////////////////////////////////////////////////////
      StRun: begin
        if (&operand_valid_i && !rq_full_i) begin
          for (int b = 0; b < int'(RowBytes); b++) begin
            src_b = int'(in_pnt_q) + b;
            dst_b = int'(out_pnt_q) + b;
            if (b < int'(step) && src_b < int'(RowBytes) && dst_b < int'(RowBytes)) begin
              // Byte k of a row sits in lane k/8, byte k mod 8
              row_d[dst_b / LaneBytes].bytes[dst_b % LaneBytes] =
                operand_i[src_b / LaneBytes].bytes[src_b % LaneBytes];
              be_d[dst_b / LaneBytes][dst_b % LaneBytes] = 1'b1;
            end
          end

          in_pnt_d  = in_pnt_q + step;
          out_pnt_d = out_pnt_q + step;
          cnt_d     = cnt_q - vlen_t'(step);

          // Source row used up, ask the lanes for the next one
          if (in_pnt_d == PntW'(RowBytes) || last) begin
            in_pnt_d        = '0;
            operand_ready_o = '1;
          end

          // Destination row full or instruction over
          if (out_pnt_d == PntW'(RowBytes) || last) begin
            out_pnt_d = '0;
            vrf_pnt_d = vrf_pnt_q + 1'b1;
            push_o    = 1'b1;
          end

          if (last) begin
            state_d      = StIdle;
            issue_done_o = 1'b1;
          end
        end
      end

      default: state_d = StIdle;
    endcase
  end

  // Row data only matters where be is set
  always_ff @(posedge clk_i) begin
    row_q <= row_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      cnt_q     <= '0;
      vrf_pnt_q <= '0;
      be_q      <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      cnt_q     <= cnt_d;
      vrf_pnt_q <= vrf_pnt_d;
      // Start an empty row after each push
      be_q      <= push_o ? '0 : be_d;
    end
  end

endmodule

// File: sldu_top.f
sldu_pkg.sv
sldu_insn_queue.sv
sldu_slide_engine.sv
sldu_result_queue.sv
sldu_top.sv
tb_clk_gen.sv
tb_sldu.sv

// File: sldu_top.sv
`timescale 1ns/1ps

module sldu_top #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned InsnQueueDepth   = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer
  input  logic                                        req_valid_i,
  input  sldu_pkg::slide_op_e                         req_op_i,
  input  sldu_pkg::vsew_e                             req_vsew_i,
  input  sldu_pkg::vlen_t                             req_vl_i,
  input  sldu_pkg::vlen_t                             req_stride_i,
  input  sldu_pkg::vreg_t                             req_vd_i,
  input  sldu_pkg::vid_t                              req_id_i,
  output logic                                        req_ready_o,
  // Lane operands
  input  sldu_pkg::lane_word_u [NrLanes-1:0]          operand_i,
  input  logic [NrLanes-1:0]                          operand_valid_i,
  output logic [NrLanes-1:0]                          operand_ready_o,
  // Lane results
  output logic [NrLanes-1:0]                          result_req_o,
  output sldu_pkg::vaddr_t [NrLanes-1:0]              result_addr_o,
  output sldu_pkg::vid_t [NrLanes-1:0]                result_id_o,
  output sldu_pkg::lane_word_u [NrLanes-1:0]          result_wdata_o,
  output logic [NrLanes-1:0][sldu_pkg::LaneBytes-1:0] result_be_o,
  input  logic [NrLanes-1:0]                          result_gnt_i,
  // Completion
  output logic [sldu_pkg::NrVInsn-1:0]                done_o
);
  import sldu_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // Queue to engine
  ////////////////////////////////////////////////////////////////////

  logic      issue_valid;
  logic      issue_done;
  slide_op_e issue_op;
  vsew_e     issue_vsew;
  vlen_t     issue_bytes;
  vlen_t     issue_offset;
  vreg_t     issue_vd;
  vid_t      issue_id;

  // Engine to result buffer
  logic                                push;
  lane_word_u [NrLanes-1:0]            push_wdata;
  logic [NrLanes-1:0][LaneBytes-1:0]   push_be;
  vaddr_t                              push_addr;
  vid_t                                push_id;
  logic                                rq_full;
  logic                                row_retired;

  sldu_insn_queue #(
    .NrLanes        (NrLanes),
    .InsnQueueDepth (InsnQueueDepth)
  ) i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_vsew_i     (req_vsew_i),
    .req_vl_i       (req_vl_i),
    .req_stride_i   (req_stride_i),
    .req_vd_i       (req_vd_i),
    .req_id_i       (req_id_i),
    .issue_done_i   (issue_done),
    .row_retired_i  (row_retired),
    .req_ready_o    (req_ready_o),
    .issue_valid_o  (issue_valid),
    .issue_op_o     (issue_op),
    .issue_vsew_o   (issue_vsew),
    .issue_bytes_o  (issue_bytes),
    .issue_offset_o (issue_offset),
    .issue_vd_o     (issue_vd),
    .issue_id_o     (issue_id),
    .done_o         (done_o)
  );

  sldu_slide_engine #(
    .NrLanes         (NrLanes)
  ) i_slide_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_valid_i   (issue_valid),
    .issue_op_i      (issue_op),
    .issue_vsew_i    (issue_vsew),
    .issue_bytes_i   (issue_bytes),
    .issue_offset_i  (issue_offset),
    .issue_vd_i      (issue_vd),
    .issue_id_i      (issue_id),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .rq_full_i       (rq_full),
    .operand_ready_o (operand_ready_o),
    .issue_done_o    (issue_done),
    .push_o          (push),
    .push_wdata_o    (push_wdata),
    .push_be_o       (push_be),
    .push_addr_o     (push_addr),
    .push_id_o       (push_id)
  );

  sldu_result_queue #(
    .NrLanes          (NrLanes),
    .ResultQueueDepth (ResultQueueDepth)
  ) i_result_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .push_i           (push),
    .push_wdata_i     (push_wdata),
    .push_be_i        (push_be),
    .push_addr_i      (push_addr),
    .push_id_i        (push_id),
    .result_gnt_i     (result_gnt_i),
    .full_o           (rq_full),
    .row_retired_o    (row_retired),
    .result_req_o     (result_req_o),
    .result_addr_o    (result_addr_o),
    .result_id_o      (result_id_o),
    .result_wdata_o   (result_wdata_o),
    .result_be_o      (result_be_o)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: tb_sldu.sv
`timescale 1ns/1ps

module tb_sldu;
  import sldu_pkg::*;

  localparam int unsigned NrLanes  = 2;
  localparam int unsigned RowBytes = NrLanes * LaneBytes;
  localparam int unsigned SrcBytes = 64 * RowBytes;
  // Byte space of all 32 destination registers
  localparam int unsigned MemBytes = 32 * RowsPerVreg * RowBytes;
  localparam int          Timeout  = 2000;

  logic clk;
  logic rst_n;

  // Sequencer side
  logic      req_valid  = 1'b0;
  slide_op_e req_op     = OP_SLIDEUP;
  vsew_e     req_vsew   = EW8;
  vlen_t     req_vl     = '0;
  vlen_t     req_stride = '0;
  vreg_t     req_vd     = '0;
  vid_t      req_id     = '0;
  logic      req_ready;

  // Lane side
  lane_word_u [NrLanes-1:0]          operand       = '0;
  logic       [NrLanes-1:0]          operand_valid = '0;
  logic       [NrLanes-1:0]          result_gnt    = '0;
  logic       [NrLanes-1:0]          operand_ready;
  logic       [NrLanes-1:0]          result_req;
  vaddr_t     [NrLanes-1:0]          result_addr;
  vid_t       [NrLanes-1:0]          result_id;
  lane_word_u [NrLanes-1:0]          result_wdata;
  logic       [NrLanes-1:0][LaneBytes-1:0] result_be;
  logic       [NrVInsn-1:0]          done;

  // Source row r byte b sits at index r*RowBytes+b
  logic [7:0] src_mem [SrcBytes];
  logic [7:0] exp_mem [MemBytes];
  logic       exp_en  [MemBytes];
  int         got_cnt [MemBytes];
  logic       row_exp [MemBytes / RowBytes];
  vid_t       row_id  [MemBytes / RowBytes];

  // Source rows still owed to the engine per instruction
  int   src_start_q [$];
  int   src_rows_q  [$];
  int   src_row     = 0;
  int   rows_left   = 0;
  vid_t order_q     [$];
  vid_t done_q      [$];

  logic        grant_en  = 1'b1;
  logic        gaps      = 1'b0;
  logic [15:0] data_lfsr = 16'd82;
  logic [15:0] gap_lfsr  = 16'd82;

  tb_clk_gen #(
    .Period      (8),
    .ResetCycles (5)
  ) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  sldu_top #(
    .NrLanes          (NrLanes),
    .InsnQueueDepth   (2),
    .ResultQueueDepth (2)
  ) UUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_valid_i     (req_valid),
    .req_op_i        (req_op),
    .req_vsew_i      (req_vsew),
    .req_vl_i        (req_vl),
    .req_stride_i    (req_stride),
    .req_vd_i        (req_vd),
    .req_id_i        (req_id),
    .req_ready_o     (req_ready),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_req_o    (result_req),
    .result_addr_o   (result_addr),
    .result_id_o     (result_id),
    .result_wdata_o  (result_wdata),
    .result_be_o     (result_be),
    .result_gnt_i    (result_gnt),
    .done_o          (done)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic gap_bit();
    gap_lfsr = lfsr_next(gap_lfsr);
    return gap_lfsr[0];
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0d ns while waiting for %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped on timeout");
  endtask

  // Eight LFSR steps per source byte
  task automatic fill_source();
    for (int i = 0; i < SrcBytes; i++) begin
      for (int k = 0; k < 8; k++) begin
        data_lfsr  = lfsr_next(data_lfsr);
        src_mem[i] = {src_mem[i][6:0], data_lfsr[0]};
      end
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < MemBytes; i++) begin
      exp_en[i]  = 1'b0;
      got_cnt[i] = 0;
    end
    for (int r = 0; r < MemBytes / RowBytes; r++) begin
      row_exp[r] = 1'b0;
    end
    order_q.delete();
    done_q.delete();
  endtask

  // Expected bytes of one slide from element counts
  task automatic model_insn(input slide_op_e op, input vsew_e vsew, input int vl,
                            input int stride, input vreg_t vd, input vid_t id);
    int vl_b;
    int off_b;
    int first;
    int base;
    int in0;
    vl_b  = vl << int'(vsew);
    off_b = stride << int'(vsew);
    first = (op == OP_SLIDEUP) ? off_b : 0;
    base  = int'(vd) * RowsPerVreg * RowBytes;
    for (int i = first; i < vl_b; i++) begin
      exp_mem[base + i] = (op == OP_SLIDEUP) ? src_mem[i - off_b] : src_mem[i + off_b];
      exp_en[base + i]  = 1'b1;
      row_exp[(base + i) / RowBytes] = 1'b1;
      row_id[(base + i) / RowBytes]  = id;
    end
    // Slidedown reads from the offset row onward
    in0 = (op == OP_SLIDEUP) ? 0 : off_b % RowBytes;
    src_start_q.push_back((op == OP_SLIDEUP) ? 0 : off_b / RowBytes);
    src_rows_q.push_back((in0 + vl_b - first + RowBytes - 1) / RowBytes);
    order_q.push_back(id);
  endtask

  task automatic drive_req(input slide_op_e op, input vsew_e vsew, input int vl,
                           input int stride, input vreg_t vd, input vid_t id);
    req_valid  <= 1'b1;
    req_op     <= op;
    req_vsew   <= vsew;
    req_vl     <= vlen_t'(vl);
    req_stride <= vlen_t'(stride);
    req_vd     <= vd;
    req_id     <= id;
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > Timeout) begin
        stop_on_timeout("instruction acceptance");
      end
    end while (!(req_valid && req_ready));
    req_valid <= 1'b0;
  endtask

  task automatic send_insn(input slide_op_e op, input vsew_e vsew, input int vl,
                           input int stride, input vreg_t vd, input vid_t id);
    model_insn(op, vsew, vl, stride, vd, id);
    drive_req(op, vsew, vl, stride, vd, id);
    wait_accept();
  endtask

  task automatic wait_done(input int n);
    int cycles;
    cycles = 0;
    while (done_q.size() < n) begin
      @(posedge clk);
      cycles++;
      if (cycles > Timeout) begin
        stop_on_timeout("done pulses");
      end
    end
  endtask

  // Checks done order and written bytes before a fresh model
  task automatic check_and_clear();
    repeat (10) @(posedge clk);
    check_equal(done_q.size(), order_q.size(), "number of done pulses");
    foreach (order_q[i]) begin
      check_equal(done_q[i], order_q[i], "done id order");
    end
    for (int i = 0; i < MemBytes; i++) begin
      if (exp_en[i]) begin
        check_equal(got_cnt[i], 1, "writes of a slide byte");
      end
    end
    check_equal(result_req, '0, "result request left after done");
    check_equal(src_start_q.size(), 0, "source rows never read");
    check_equal(rows_left, 0, "source rows left unread");
    clear_model();
    fill_source();
  endtask

  // One granted lane word against the model
  task automatic record_lane(input int l);
    int base;
    base = int'(result_addr[l]) * RowBytes + l * LaneBytes;
    check_equal(row_exp[result_addr[l]], 1'b1, "request to a row outside the slide");
    check_equal(result_id[l], row_id[result_addr[l]], "result id");
    for (int k = 0; k < LaneBytes; k++) begin
      if (result_be[l][k]) begin
        check_equal(exp_en[base + k], 1'b1, "byte enable outside the slide");
        check_equal(result_wdata[l].bytes[k], exp_mem[base + k], "result byte");
        got_cnt[base + k]++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Lane responder and done monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      // Engine took the current source row at this edge
      if ((operand_ready & operand_valid) != '0) begin
        check_equal(rows_left > 0, 1'b1, "operand ready with no row pending");
        src_row++;
        rows_left--;
      end
      if (rows_left == 0 && src_start_q.size() != 0) begin
        src_row   = src_start_q.pop_front();
        rows_left = src_rows_q.pop_front();
      end
      for (int l = 0; l < NrLanes; l++) begin
        // Row byte b sits in lane b/8
        for (int k = 0; k < LaneBytes; k++) begin
          operand[l].bytes[k] <= src_mem[src_row * RowBytes + l * LaneBytes + k];
        end
        operand_valid[l] <= (rows_left != 0) && (!gaps || gap_bit());
        if (result_req[l] && result_gnt[l]) begin
          record_lane(l);
        end
        result_gnt[l] <= grant_en && (!gaps || gap_bit());
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && done != '0) begin
      check_equal($countones(done), 1, "done pulse not one-hot");
      for (int i = 0; i < NrVInsn; i++) begin
        if (done[i]) begin
          done_q.push_back(vid_t'(i));
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_slideup_ew8();
    send_insn(OP_SLIDEUP, EW8, 20, 3, 5'd2, 3'd0);
    wait_done(1);
    check_and_clear();
  endtask

  task automatic test_slidedown_ew32();
    send_insn(OP_SLIDEDOWN, EW32, 6, 5, 5'd3, 3'd1);
    wait_done(1);
    check_and_clear();
  endtask

  // Offsets past the first row with partial first and last rows
  task automatic test_wide_offsets();
    send_insn(OP_SLIDEUP, EW16, 40, 10, 5'd3, 3'd2);
    send_insn(OP_SLIDEDOWN, EW64, 5, 3, 5'd4, 3'd3);
    send_insn(OP_SLIDEUP, EW64, 6, 3, 5'd5, 3'd4);
    send_insn(OP_SLIDEDOWN, EW16, 20, 12, 5'd6, 3'd5);
    wait_done(4);
    check_and_clear();
  endtask

  task automatic test_back_pressure();
    gaps <= 1'b1;
    send_insn(OP_SLIDEUP, EW8, 20, 3, 5'd2, 3'd6);
    send_insn(OP_SLIDEDOWN, EW16, 20, 12, 5'd7, 3'd7);
    wait_done(2);
    gaps <= 1'b0;
    check_and_clear();
  endtask

  task automatic test_queue_fill();
    grant_en <= 1'b0;
    send_insn(OP_SLIDEUP, EW8, 20, 3, 5'd8, 3'd1);
    send_insn(OP_SLIDEDOWN, EW32, 6, 5, 5'd9, 3'd2);
    model_insn(OP_SLIDEUP, EW16, 40, 10, 5'd10, 3'd3);
    drive_req(OP_SLIDEUP, EW16, 40, 10, 5'd10, 3'd3);
    // Both slots held while no row can retire
    repeat (12) begin
      @(posedge clk);
      check_equal(req_ready, 1'b0, "req_ready with a full instruction queue");
    end
    grant_en <= 1'b1;
    wait_accept();
    wait_done(3);
    check_and_clear();
  endtask

  initial begin
    int cycles;
    cycles = 0;
    fill_source();
    clear_model();
    while (!rst_n) begin
      @(posedge clk);
      cycles++;
      if (cycles > Timeout) begin
        stop_on_timeout("reset release");
      end
    end
    // Idle outputs after reset
    check_equal(result_req, '0, "result request after reset");
    check_equal(operand_ready, '0, "operand ready after reset");
    check_equal(done, '0, "done after reset");
    check_equal(req_ready, 1'b1, "req_ready after reset");

    test_slideup_ew8();
    test_slidedown_ew32();
    test_wide_offsets();
    test_back_pressure();
    test_queue_fill();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
